/* design/sram_test_pkg.sv */
`default_nettype none

package sram_test_pkg;

  // sram geometry
  localparam int addr_bits = 4;
  localparam int data_bits = 16;

  // expected fifo holds 2**fifo_depth_bits entries
  localparam int fifo_depth_bits = 2;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [data_bits-1:0] data_t;

  // test patterns in the order they are applied
  typedef enum logic [2:0] {
    pat_zeros,
    pat_ones,
    pat_checker,
    pat_inverse,
    pat_address
  } pattern_e;

  typedef enum logic [2:0] {
    seq_start,
    seq_write,
    seq_read,
    seq_next_pattern,
    seq_done,
    seq_halt
  } seq_state_e;

endpackage

`default_nettype wire

/* design/address_iterator.sv */
`timescale 1ns/1ps
`default_nettype none

module address_iterator (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   clear,
  input  wire                   step,
  output sram_test_pkg::addr_t  addr,
  output logic                  last
);

  // wraps back to zero after the top address
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      addr <= '0;
    end else if (step) begin
      addr <= addr + 1'b1;
    end
  end

  // top address ends a write or read phase
  assign last = (addr == '1);

endmodule

`default_nettype wire

/* design/pattern_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_generator (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      restart,
  input  wire                      next_pattern,
  input  wire sram_test_pkg::addr_t addr,
  output sram_test_pkg::pattern_e  pattern,
  output sram_test_pkg::data_t     word,
  output logic                     final_pattern
);

  assign final_pattern = (pattern == sram_test_pkg::pat_address);

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      pattern <= sram_test_pkg::pat_zeros;
    end else if (next_pattern && !final_pattern) begin
      pattern <= sram_test_pkg::pattern_e'(pattern + 3'd1);
    end
  end

  // data word for the current pattern and address
  always_comb begin
    case (pattern)
      sram_test_pkg::pat_zeros: begin
        word = '0;
      end
      sram_test_pkg::pat_ones: begin
        word = '1;
      end
      sram_test_pkg::pat_checker: begin
        word = 16'h5555;
      end
      sram_test_pkg::pat_inverse: begin
        word = 16'haaaa;
      end
      sram_test_pkg::pat_address: begin
        word = sram_test_pkg::data_t'(addr);
      end
      default: begin
        word = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/expected_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module expected_fifo (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       push,
  input  wire sram_test_pkg::data_t push_data,
  input  wire sram_test_pkg::addr_t push_addr,
  input  wire                       pop,
  output sram_test_pkg::data_t      pop_data,
  output sram_test_pkg::addr_t      pop_addr,
  output logic                      full,
  output logic                      empty
);

  localparam int depth_bits = sram_test_pkg::fifo_depth_bits;

  sram_test_pkg::data_t data_mem [2**depth_bits];
  sram_test_pkg::addr_t addr_mem [2**depth_bits];

  // extra msb tells a full fifo from an empty one
  logic [depth_bits:0] wr_ptr;
  logic [depth_bits:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[depth_bits] != rd_ptr[depth_bits]) &&
                 (wr_ptr[depth_bits-1:0] == rd_ptr[depth_bits-1:0]);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) begin
      data_mem[wr_ptr[depth_bits-1:0]] <= push_data;
      addr_mem[wr_ptr[depth_bits-1:0]] <= push_addr;
    end
  end

  // head entry visible without read latency
  assign pop_data = data_mem[rd_ptr[depth_bits-1:0]];
  assign pop_addr = addr_mem[rd_ptr[depth_bits-1:0]];

endmodule

`default_nettype wire

/* design/sram_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_controller (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       wr_valid,
  output logic                      wr_ready,
  input  wire sram_test_pkg::addr_t wr_addr,
  input  wire sram_test_pkg::data_t wr_data,
  input  wire                       rd_valid,
  output logic                      rd_ready,
  input  wire sram_test_pkg::addr_t rd_addr,
  output logic                      rdata_valid,
  output sram_test_pkg::data_t      rdata,
  output sram_test_pkg::addr_t      sram_addr,
  inout  wire sram_test_pkg::data_t sram_data,
  output logic                      sram_ce_n,
  output logic                      sram_we_n,
  output logic                      sram_oe_n
);

  typedef enum logic [1:0] {
    ctl_idle,
    ctl_write,
    ctl_read,
    ctl_return
  } ctl_state_e;

  ctl_state_e           state;
  sram_test_pkg::data_t wr_word;
  logic                 drive;

  // write wins if both are offered
  assign wr_ready    = (state == ctl_idle);
  assign rd_ready    = (state == ctl_idle) && !wr_valid;
  assign rdata_valid = (state == ctl_return);

  assign sram_data = drive ? wr_word : 'z;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ctl_idle;
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      drive     <= 1'b0;
    end else begin
      case (state)
        ctl_idle: begin
          if (wr_valid) begin
            state     <= ctl_write;
            sram_ce_n <= 1'b0;
            sram_we_n <= 1'b0;
            drive     <= 1'b1;
          end else if (rd_valid) begin
            state     <= ctl_read;
            sram_ce_n <= 1'b0;
            sram_oe_n <= 1'b0;
          end
        end
        // single strobe cycle, then release the bus
        ctl_write: begin
          state     <= ctl_idle;
          sram_ce_n <= 1'b1;
          sram_we_n <= 1'b1;
          drive     <= 1'b0;
        end
        ctl_read: begin
          state     <= ctl_return;
          sram_ce_n <= 1'b1;
          sram_oe_n <= 1'b1;
        end
        default: begin
          state <= ctl_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ctl_idle) begin
      if (wr_valid) begin
        sram_addr <= wr_addr;
        wr_word   <= wr_data;
      end else if (rd_valid) begin
        sram_addr <= rd_addr;
      end
    end
    // bus is sampled at the end of the oe cycle
    if (state == ctl_read) begin
      rdata <= sram_data;
    end
  end

endmodule

`default_nettype wire

/* design/test_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module test_sequencer (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       test_pass,
  output logic                      wr_valid,
  input  wire                       wr_ready,
  output sram_test_pkg::addr_t      wr_addr,
  output sram_test_pkg::data_t      wr_data,
  output logic                      rd_valid,
  input  wire                       rd_ready,
  output sram_test_pkg::addr_t      rd_addr,
  input  wire sram_test_pkg::addr_t addr,
  input  wire                       last,
  output logic                      step,
  output logic                      clear,
  input  wire sram_test_pkg::data_t word,
  input  wire                       final_pattern,
  output logic                      next_pattern,
  output logic                      restart,
  output logic                      push,
  output sram_test_pkg::data_t      push_data,
  output sram_test_pkg::addr_t      push_addr,
  input  wire                       fifo_full,
  output logic                      test_done
);

  sram_test_pkg::seq_state_e state;
  sram_test_pkg::seq_state_e next_state;

  logic write_start;
  logic read_start;
  logic last_req;
  logic write_accepted;
  logic read_accepted;

  assign write_accepted = wr_valid && wr_ready;
  assign read_accepted  = rd_valid && rd_ready;
  assign step           = write_start || read_start;
  assign test_done      = (state == sram_test_pkg::seq_done);

  always_comb begin
    next_state   = state;
    write_start  = 1'b0;
    read_start   = 1'b0;
    clear        = 1'b0;
    next_pattern = 1'b0;
    restart      = 1'b0;
    if (!test_pass) begin
      next_state = sram_test_pkg::seq_halt;
    end else begin
      case (state)
        sram_test_pkg::seq_start: begin
          clear      = 1'b1;
          restart    = 1'b1;
          next_state = sram_test_pkg::seq_write;
        end
        sram_test_pkg::seq_write: begin
          if (write_accepted && last_req) begin
            next_state = sram_test_pkg::seq_read;
            read_start = !fifo_full;
          end else if (write_accepted || !wr_valid) begin
            write_start = 1'b1;
          end
        end
        sram_test_pkg::seq_read: begin
          if (read_accepted && last_req) begin
            if (final_pattern) begin
              next_state = sram_test_pkg::seq_done;
              restart    = 1'b1;
            end else begin
              next_state   = sram_test_pkg::seq_next_pattern;
              next_pattern = 1'b1;
            end
          end else if ((read_accepted || !rd_valid) && !fifo_full) begin
            // waits here with rd_valid low while the fifo is full
            read_start = 1'b1;
          end
        end
        sram_test_pkg::seq_next_pattern, sram_test_pkg::seq_done: begin
          next_state  = sram_test_pkg::seq_write;
          write_start = 1'b1;
        end
        default: begin
          next_state = sram_test_pkg::seq_halt;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= sram_test_pkg::seq_start;
      wr_valid <= 1'b0;
      rd_valid <= 1'b0;
      push     <= 1'b0;
      last_req <= 1'b0;
    end else begin
      state <= next_state;
      push  <= read_start;
      if (write_start) begin
        wr_valid <= 1'b1;
      end else if (write_accepted) begin
        wr_valid <= 1'b0;
      end
      if (read_start) begin
        rd_valid <= 1'b1;
      end else if (read_accepted) begin
        rd_valid <= 1'b0;
      end
      // remembers whether the issued request ends the phase
      if (step) begin
        last_req <= last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_start) begin
      wr_addr <= addr;
      wr_data <= word;
    end
    if (read_start) begin
      rd_addr   <= addr;
      push_addr <= addr;
      push_data <= word;
    end
  end

endmodule

`default_nettype wire

/* design/read_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module read_checker (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       rdata_valid,
  input  wire sram_test_pkg::data_t rdata,
  input  wire sram_test_pkg::data_t exp_data,
  input  wire sram_test_pkg::addr_t exp_addr,
  output logic                      pop,
  output logic                      test_pass,
  output sram_test_pkg::addr_t      fail_addr,
  output sram_test_pkg::data_t      fail_read,
  output sram_test_pkg::data_t      fail_expected
);

  logic mismatch;

  // one fifo entry per returned word
  assign pop      = rdata_valid;
  assign mismatch = rdata_valid && (rdata != exp_data);

  // sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      test_pass <= 1'b1;
    end else if (mismatch) begin
      test_pass <= 1'b0;
    end
  end

  // only the first failure is kept
  always_ff @(posedge clk) begin
    if (mismatch && test_pass) begin
      fail_addr     <= exp_addr;
      fail_read     <= rdata;
      fail_expected <= exp_data;
    end
  end

endmodule

`default_nettype wire

/* design/sram_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_test_top (
  input  wire                       clk,
  input  wire                       reset,
  output logic                      test_done,
  output logic                      test_pass,
  output sram_test_pkg::pattern_e   pattern,
  output sram_test_pkg::addr_t      fail_addr,
  output sram_test_pkg::data_t      fail_read,
  output sram_test_pkg::data_t      fail_expected,
  output sram_test_pkg::addr_t      sram_addr,
  inout  wire sram_test_pkg::data_t sram_data,
  output logic                      sram_ce_n,
  output logic                      sram_we_n,
  output logic                      sram_oe_n
);

  // request channels
  logic                 wr_valid;
  logic                 wr_ready;
  sram_test_pkg::addr_t wr_addr;
  sram_test_pkg::data_t wr_data;
  logic                 rd_valid;
  logic                 rd_ready;
  sram_test_pkg::addr_t rd_addr;
  logic                 rdata_valid;
  sram_test_pkg::data_t rdata;

  // iterator and patterns
  sram_test_pkg::addr_t iter_addr;
  logic                 iter_last;
  logic                 iter_step;
  logic                 iter_clear;
  sram_test_pkg::data_t word;
  logic                 final_pattern;
  logic                 next_pattern;
  logic                 restart;

  // expected values in flight
  logic                 push;
  sram_test_pkg::data_t push_data;
  sram_test_pkg::addr_t push_addr;
  logic                 pop;
  sram_test_pkg::data_t exp_data;
  sram_test_pkg::addr_t exp_addr;
  logic                 fifo_full;

  address_iterator iter0 (
    .clk  (clk),
    .reset(reset),
    .clear(iter_clear),
    .step (iter_step),
    .addr (iter_addr),
    .last (iter_last)
  );

  pattern_generator pat0 (
    .clk          (clk),
    .reset        (reset),
    .restart      (restart),
    .next_pattern (next_pattern),
    .addr         (iter_addr),
    .pattern      (pattern),
    .word         (word),
    .final_pattern(final_pattern)
  );

  expected_fifo fifo0 (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .push_data(push_data),
    .push_addr(push_addr),
    .pop      (pop),
    .pop_data (exp_data),
    .pop_addr (exp_addr),
    .full     (fifo_full),
    .empty    ()
  );

  sram_controller ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .wr_valid   (wr_valid),
    .wr_ready   (wr_ready),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_valid   (rd_valid),
    .rd_ready   (rd_ready),
    .rd_addr    (rd_addr),
    .rdata_valid(rdata_valid),
    .rdata      (rdata),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_ce_n  (sram_ce_n),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n)
  );

  test_sequencer seq0 (
    .clk          (clk),
    .reset        (reset),
    .test_pass    (test_pass),
    .wr_valid     (wr_valid),
    .wr_ready     (wr_ready),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_valid     (rd_valid),
    .rd_ready     (rd_ready),
    .rd_addr      (rd_addr),
    .addr         (iter_addr),
    .last         (iter_last),
    .step         (iter_step),
    .clear        (iter_clear),
    .word         (word),
    .final_pattern(final_pattern),
    .next_pattern (next_pattern),
    .restart      (restart),
    .push         (push),
    .push_data    (push_data),
    .push_addr    (push_addr),
    .fifo_full    (fifo_full),
    .test_done    (test_done)
  );

  read_checker chk0 (
    .clk          (clk),
    .reset        (reset),
    .rdata_valid  (rdata_valid),
    .rdata        (rdata),
    .exp_data     (exp_data),
    .exp_addr     (exp_addr),
    .pop          (pop),
    .test_pass    (test_pass),
    .fail_addr    (fail_addr),
    .fail_read    (fail_read),
    .fail_expected(fail_expected)
  );

endmodule

`default_nettype wire

/* tb/sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_model (
  input  wire sram_test_pkg::addr_t addr,
  inout  wire sram_test_pkg::data_t data,
  input  wire                       ce_n,
  input  wire                       we_n,
  input  wire                       oe_n,
  input  wire                       fault_en,
  input  wire sram_test_pkg::addr_t fault_addr,
  input  wire [3:0]                 fault_bit,
  input  wire                       fault_value
);

  sram_test_pkg::data_t mem [2**sram_test_pkg::addr_bits];
  sram_test_pkg::data_t read_word;

  // stuck bit only shows on the way out and storage stays intact
  always_comb begin
    read_word = mem[addr];
    if (fault_en && (addr == fault_addr)) begin
      read_word[fault_bit] = fault_value;
    end
  end

  assign data = (!ce_n && !oe_n && we_n) ? read_word : 'z;

  // address and data settle shortly after the strobe falls
  always @(negedge we_n) begin
    #1;
    if (!ce_n) begin
      mem[addr] = data;
    end
  end

endmodule

`default_nettype wire

/* tb/sram_test_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_test_tb;

  localparam int num_rows   = 8;
  localparam int first_rand = 4;
  localparam int wait_limit = 2000;

  logic                    clk;
  logic                    reset;
  logic                    fault_en;
  sram_test_pkg::addr_t    fault_addr;
  logic [3:0]              fault_bit;
  logic                    fault_value;
  logic                    test_done;
  logic                    test_pass;
  sram_test_pkg::pattern_e pattern;
  sram_test_pkg::addr_t    fail_addr;
  sram_test_pkg::data_t    fail_read;
  sram_test_pkg::data_t    fail_expected;
  sram_test_pkg::addr_t    sram_addr;
  wire sram_test_pkg::data_t sram_data;
  logic                    sram_ce_n;
  logic                    sram_we_n;
  logic                    sram_oe_n;

  // one row of stimulus and expected values per scenario
  logic                    row_fault_en [num_rows];
  sram_test_pkg::addr_t    row_addr     [num_rows];
  logic [3:0]              row_bit      [num_rows];
  logic                    row_value    [num_rows];
  sram_test_pkg::addr_t    row_exp_addr [num_rows];
  sram_test_pkg::data_t    row_exp_read [num_rows];
  sram_test_pkg::data_t    row_exp_word [num_rows];
  sram_test_pkg::pattern_e row_exp_pat  [num_rows];

  int          errors;
  int          rows_passed;
  int          rows_failed;
  logic [31:0] rand_state;

  sram_test_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .test_done    (test_done),
    .test_pass    (test_pass),
    .pattern      (pattern),
    .fail_addr    (fail_addr),
    .fail_read    (fail_read),
    .fail_expected(fail_expected),
    .sram_addr    (sram_addr),
    .sram_data    (sram_data),
    .sram_ce_n    (sram_ce_n),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n)
  );

  sram_model mem0 (
    .addr       (sram_addr),
    .data       (sram_data),
    .ce_n       (sram_ce_n),
    .we_n       (sram_we_n),
    .oe_n       (sram_oe_n),
    .fault_en   (fault_en),
    .fault_addr (fault_addr),
    .fault_bit  (fault_bit),
    .fault_value(fault_value)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // word each pattern writes at an address
  function automatic sram_test_pkg::data_t pattern_word(input sram_test_pkg::pattern_e pat,
                                                        input sram_test_pkg::addr_t a);
    case (pat)
      sram_test_pkg::pat_zeros:   return 16'h0000;
      sram_test_pkg::pat_ones:    return 16'hffff;
      sram_test_pkg::pat_checker: return 16'h5555;
      sram_test_pkg::pat_inverse: return 16'haaaa;
      default:                    return {12'h000, a};
    endcase
  endfunction

  task automatic set_row(input int r, input logic en, input sram_test_pkg::addr_t a,
                         input logic [3:0] b, input logic v);
    row_fault_en[r] = en;
    row_addr[r]     = a;
    row_bit[r]      = b;
    row_value[r]    = v;
  endtask

  // first failure follows from the pattern order
  task automatic predict_row(input int r);
    sram_test_pkg::pattern_e pat;
    sram_test_pkg::data_t    word;
    pat  = sram_test_pkg::pat_zeros;
    word = pattern_word(pat, row_addr[r]);
    while (word[row_bit[r]] == row_value[r] && pat != sram_test_pkg::pat_address) begin
      pat  = sram_test_pkg::pattern_e'(pat + 3'd1);
      word = pattern_word(pat, row_addr[r]);
    end
    row_exp_addr[r] = row_addr[r];
    row_exp_word[r] = word;
    row_exp_read[r] = word;
    row_exp_read[r][row_bit[r]] = row_value[r];
    // last read of a pattern returns after the pattern has moved on
    if (row_addr[r] == '1) begin
      if (pat == sram_test_pkg::pat_address) begin
        pat = sram_test_pkg::pat_zeros;
      end else begin
        pat = sram_test_pkg::pattern_e'(pat + 3'd1);
      end
    end
    row_exp_pat[r] = pat;
  endtask

  task automatic fill_table();
    int r;
    set_row(0, 1'b0, 4'h0, 4'd0, 1'b0);
    // stuck-at-0 needs the ones pattern to show
    set_row(1, 1'b1, 4'h9, 4'd3, 1'b0);
    row_exp_addr[1] = 4'h9;
    row_exp_read[1] = 16'hfff7;
    row_exp_word[1] = 16'hffff;
    row_exp_pat[1]  = sram_test_pkg::pat_ones;
    set_row(2, 1'b1, 4'h2, 4'd0, 1'b1);
    row_exp_addr[2] = 4'h2;
    row_exp_read[2] = 16'h0001;
    row_exp_word[2] = 16'h0000;
    row_exp_pat[2]  = sram_test_pkg::pat_zeros;
    // at the top address the pattern has already advanced to ones
    set_row(3, 1'b1, 4'hf, 4'd15, 1'b1);
    row_exp_addr[3] = 4'hf;
    row_exp_read[3] = 16'h8000;
    row_exp_word[3] = 16'h0000;
    row_exp_pat[3]  = sram_test_pkg::pat_ones;
    rand_state = 32'd23761;
    for (r = first_rand; r < num_rows; r++) begin
      rand_state = lcg_next(rand_state);
      set_row(r, 1'b1, rand_state[19:16], rand_state[27:24], rand_state[30]);
      predict_row(r);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic apply_reset(input int r);
    @(negedge clk);
    reset       = 1'b1;
    fault_en    = row_fault_en[r];
    fault_addr  = row_addr[r];
    fault_bit   = row_bit[r];
    fault_value = row_value[r];
    repeat (10) @(negedge clk);
    reset = 1'b0;
  endtask

  // stops at a done pulse or a pass drop
  task automatic wait_for_outcome(output logic timed_out);
    int cycles;
    timed_out = 1'b1;
    for (cycles = 0; cycles < wait_limit; cycles++) begin
      @(negedge clk);
      if (test_done || !test_pass) begin
        timed_out = 1'b0;
        break;
      end
    end
  endtask

  task automatic run_row(input int r);
    logic timed_out;
    int   errors_before;
    int   pass_num;
    errors_before = errors;
    apply_reset(r);
    if (!row_fault_en[r]) begin
      // a clean run starts its next pass by itself
      for (pass_num = 0; pass_num < 2; pass_num++) begin
        wait_for_outcome(timed_out);
        if (timed_out) begin
          $display("row %0d: pass %0d never finished within %0d cycles", r, pass_num, wait_limit);
          errors++;
        end else begin
          check_value("test_done", 32'(test_done), 32'd1);
          check_value("test_pass", 32'(test_pass), 32'd1);
        end
      end
    end else begin
      wait_for_outcome(timed_out);
      if (timed_out) begin
        $display("row %0d: fault was not detected within %0d cycles", r, wait_limit);
        errors++;
      end else begin
        check_value("test_done", 32'(test_done), 32'd0);
        check_value("test_pass", 32'(test_pass), 32'd0);
        check_value("fail_addr", 32'(fail_addr), 32'(row_exp_addr[r]));
        check_value("fail_read", 32'(fail_read), 32'(row_exp_read[r]));
        check_value("fail_expected", 32'(fail_expected), 32'(row_exp_word[r]));
        check_value("pattern", 32'(pattern), 32'(row_exp_pat[r]));
      end
    end
    if (errors == errors_before) begin
      $display("row %0d fault_en=%0d addr=%h bit=%0d value=%0d: ok", r,
               row_fault_en[r], row_addr[r], row_bit[r], row_value[r]);
      rows_passed++;
    end else begin
      $display("row %0d fault_en=%0d addr=%h bit=%0d value=%0d: failed", r,
               row_fault_en[r], row_addr[r], row_bit[r], row_value[r]);
      rows_failed++;
    end
  endtask

  initial begin
    int r;
    reset       = 1'b1;
    fault_en    = 1'b0;
    fault_addr  = '0;
    fault_bit   = '0;
    fault_value = 1'b0;
    errors      = 0;
    rows_passed = 0;
    rows_failed = 0;
    fill_table();
    for (r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("%0d rows passed, %0d rows failed, %0d errors", rows_passed, rows_failed, errors);
    if (errors == 0 && rows_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sram_test_top.f */
design/sram_test_pkg.sv
design/address_iterator.sv
design/pattern_generator.sv
design/expected_fifo.sv
design/sram_controller.sv
design/test_sequencer.sv
design/read_checker.sv
design/sram_test_top.sv
tb/sram_model.sv
tb/sram_test_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       := sram_test_tb
FILELIST  := sram_test_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
